//--- rtl/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

////////////////////
// Ring size
////////////////////
`define NUM_PORTS       8
`define PORT_ID_W       3

// Port roles on the ring
`define PORT_CTRL       0
`define PORT_MSG        1
`define PORT_IO_FIRST   2
`define NUM_IO_PORTS    6

////////////////////
// Packet fields
////////////////////
`define PACKET_W        66
`define PAYLOAD_W       56
// Address fields carry one reserved high bit
`define PKT_ADDR_W      4
`define PKT_KIND_W      2

// One message beat fills one packet payload
`define MSG_BEAT_W      `PAYLOAD_W

`endif

//--- rtl/noc_pkg.sv
`include "noc_params.svh"

package noc_pkg;

	////////////////////
	// Addressing
	////////////////////

	// Index of a router port on the ring
	typedef logic [`PORT_ID_W-1:0] port_id_t;

	////////////////////
	// Packet format
	////////////////////

	// Packet opcode
	typedef enum logic [`PKT_KIND_W-1:0] {
		PKT_DATA = 2'd0,
		PKT_CTRL = 2'd1,
		PKT_MSG  = 2'd2
	} pkt_kind_e;

	// Network packet, dest sits in the top bits
	typedef struct packed {
		logic [`PKT_ADDR_W-1:0] dest;
		logic [`PKT_ADDR_W-1:0] src;
		pkt_kind_e              kind;
		logic [`PAYLOAD_W-1:0]  payload;
	} packet_t;

	////////////////////
	// Message interface
	////////////////////

	// Receive session state
	typedef enum logic [1:0] {
		MSG_IDLE = 2'd0,
		MSG_ACK  = 2'd1,
		MSG_DATA = 2'd2
	} msg_state_e;

endpackage

//--- rtl/ring_router_node.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module ring_router_node
	import noc_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,

	input  port_id_t i_node_id,

	// Slot arriving from the previous node
	input  logic     i_ring_valid,
	input  packet_t  i_ring_pkt,

	// Slot leaving towards the next node
	output logic     o_ring_valid,
	output packet_t  o_ring_pkt,

	// Local injection
	input  logic     i_inj_valid,
	output logic     o_inj_accept,
	input  packet_t  i_inj_pkt,

	// Local ejection
	output logic     o_ej_valid,
	input  logic     i_ej_accept,
	output packet_t  o_ej_pkt
);

	logic    run_q;
	logic    slot_valid_q;
	packet_t slot_pkt_q;

	logic    addr_hit;
	logic    ej_take;
	logic    slot_free;
	logic    inj_take;

	////////////////////
	// Eject side
	////////////////////

	// Reserved high dest bit is not part of the match
	assign addr_hit   = (i_ring_pkt.dest[`PORT_ID_W-1:0] == i_node_id);
	assign o_ej_valid = i_ring_valid && addr_hit;
	assign o_ej_pkt   = i_ring_pkt;
	assign ej_take    = o_ej_valid && i_ej_accept;

	////////////////////
	// Inject side
	////////////////////

	// Through-traffic first, inject only into an empty or vacated slot
	assign slot_free    = !i_ring_valid || ej_take;
	assign o_inj_accept = run_q && slot_free;
	assign inj_take     = i_inj_valid && o_inj_accept;

	// Slot valid and node enable
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			run_q        <= 1'b0;
			slot_valid_q <= 1'b0;
		end else begin
			run_q        <= 1'b1;
			slot_valid_q <= slot_free ? inj_take : 1'b1;
		end
	end

	// Refused ejects stay in the slot and go round again
	always_ff @(posedge i_clk) begin
		if (slot_free) begin
			slot_pkt_q <= i_inj_pkt;
		end else begin
			slot_pkt_q <= i_ring_pkt;
		end
	end

	assign o_ring_valid = slot_valid_q;
	assign o_ring_pkt   = slot_pkt_q;

endmodule

//--- rtl/tile_router_network.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module tile_router_network
	import noc_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_rst_n,

	// Inject ports, one per router port
	input  logic    i_inj_valid  [`NUM_PORTS],
	output logic    o_inj_accept [`NUM_PORTS],
	input  packet_t i_inj_pkt    [`NUM_PORTS],

	// Eject ports, one per router port
	output logic    o_ej_valid   [`NUM_PORTS],
	input  logic    i_ej_accept  [`NUM_PORTS],
	output packet_t o_ej_pkt     [`NUM_PORTS]
);

	// Slot register outputs, indexed by the node that owns them
	wire          ring_valid [`NUM_PORTS];
	wire packet_t ring_pkt   [`NUM_PORTS];

	////////////////////
	// Ring of nodes
	////////////////////

	for (genvar n = 0; n < `NUM_PORTS; n++) begin : g_node
		// Upstream neighbour, node 0 closes the ring from the last node
		localparam int prev_idx = (n + `NUM_PORTS - 1) % `NUM_PORTS;

		ring_router_node u_node (
			.i_clk        (i_clk),
			.i_rst_n      (i_rst_n),

			.i_node_id    (port_id_t'(n)),

			.i_ring_valid (ring_valid[prev_idx]),
			.i_ring_pkt   (ring_pkt[prev_idx]),

			.o_ring_valid (ring_valid[n]),
			.o_ring_pkt   (ring_pkt[n]),

			.i_inj_valid  (i_inj_valid[n]),
			.o_inj_accept (o_inj_accept[n]),
			.i_inj_pkt    (i_inj_pkt[n]),

			.o_ej_valid   (o_ej_valid[n]),
			.i_ej_accept  (i_ej_accept[n]),
			.o_ej_pkt     (o_ej_pkt[n])
		);
	end

endmodule

//--- rtl/msg_intf.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module msg_intf
	import noc_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst_n,

	// Host receive session
	input  logic                  i_recv_msg_request,
	input  port_id_t              i_recv_msg_dest,
	output logic                  o_recv_msg_ack,

	input  logic                  i_recv_msg_valid,
	input  logic                  i_recv_msg_last,
	input  logic [`MSG_BEAT_W-1:0] i_recv_msg_payload,
	output logic                  o_recv_msg_accept,

	// Host send side
	output logic                  o_send_msg_valid,
	input  logic                  i_send_msg_dst_rdy,
	output logic [`MSG_BEAT_W-1:0] o_send_msg_payload,
	output port_id_t              o_send_msg_src,
	output pkt_kind_e             o_send_msg_kind,

	// Towards the router inject port
	output logic                  o_pkt_out_valid,
	input  logic                  i_pkt_out_accept,
	output packet_t               o_pkt_out,

	// From the router eject port
	input  logic                  i_pkt_in_valid,
	output logic                  o_pkt_in_accept,
	input  packet_t               i_pkt_in
);

	msg_state_e state_q;
	msg_state_e state_d;
	port_id_t   dest_q;
	logic       beat_xfer;

	////////////////////
	// Receive FSM
	////////////////////

	assign beat_xfer = o_pkt_out_valid && i_pkt_out_accept;

	always_comb begin
		state_d = state_q;
		case (state_q)
			MSG_IDLE: begin
				if (i_recv_msg_request) begin
					state_d = MSG_ACK;
				end
			end
			// Ack lasts one cycle, beats may follow right after
			MSG_ACK: state_d = MSG_DATA;
			MSG_DATA: begin
				if (beat_xfer && i_recv_msg_last) begin
					state_d = MSG_IDLE;
				end
			end
			default: state_d = MSG_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= MSG_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Session destination
	always_ff @(posedge i_clk) begin
		if (state_q == MSG_IDLE && i_recv_msg_request) begin
			dest_q <= i_recv_msg_dest;
		end
	end

	assign o_recv_msg_ack = (state_q == MSG_ACK);

	// One beat per packet, accepted in the same cycle the node takes it
	assign o_pkt_out_valid   = (state_q == MSG_DATA) && i_recv_msg_valid;
	assign o_recv_msg_accept = (state_q == MSG_DATA) && i_pkt_out_accept;

	assign o_pkt_out.dest    = {1'b0, dest_q};
	assign o_pkt_out.src     = `PKT_ADDR_W'(`PORT_MSG);
	assign o_pkt_out.kind    = PKT_MSG;
	assign o_pkt_out.payload = i_recv_msg_payload;

	////////////////////
	// Send side
	////////////////////

	assign o_send_msg_valid   = i_pkt_in_valid;
	assign o_pkt_in_accept    = i_send_msg_dst_rdy;
	assign o_send_msg_payload = i_pkt_in.payload;
	assign o_send_msg_src     = i_pkt_in.src[`PORT_ID_W-1:0];
	assign o_send_msg_kind    = i_pkt_in.kind;

endmodule

//--- rtl/layer_engine_docker.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module layer_engine_docker
	import noc_pkg::*;
(
	input  logic                                     i_clk,
	input  logic                                     i_rst_n,

	// Message interface, host side
	input  logic                                     i_recv_msg_request,
	input  port_id_t                                 i_recv_msg_dest,
	output logic                                     o_recv_msg_ack,
	input  logic                                     i_recv_msg_valid,
	input  logic                                     i_recv_msg_last,
	input  logic [`MSG_BEAT_W-1:0]                   i_recv_msg_payload,
	output logic                                     o_recv_msg_accept,

	output logic                                     o_send_msg_valid,
	input  logic                                     i_send_msg_dst_rdy,
	output logic [`MSG_BEAT_W-1:0]                   o_send_msg_payload,
	output port_id_t                                 o_send_msg_src,
	output pkt_kind_e                                o_send_msg_kind,

	// Layer-engine controller
	input  logic                                     i_layer_eng_ctrl_output_valid,
	output logic                                     o_layer_eng_ctrl_output_accept,
	input  logic [`PACKET_W-1:0]                     i_layer_eng_ctrl_output_data,
	output logic                                     o_layer_eng_ctrl_input_valid,
	input  logic                                     i_layer_eng_ctrl_input_accept,
	output logic [`PACKET_W-1:0]                     o_layer_eng_ctrl_input_data,

	// Layer-engine IO ports
	input  logic [`NUM_IO_PORTS-1:0]                 i_layer_eng_io_output_valid,
	output logic [`NUM_IO_PORTS-1:0]                 o_layer_eng_io_output_accept,
	input  logic [`NUM_IO_PORTS-1:0][`PACKET_W-1:0]  i_layer_eng_io_output_data,
	output logic [`NUM_IO_PORTS-1:0]                 o_layer_eng_io_input_valid,
	input  logic [`NUM_IO_PORTS-1:0]                 i_layer_eng_io_input_accept,
	output logic [`NUM_IO_PORTS-1:0][`PACKET_W-1:0]  o_layer_eng_io_input_data
);

	// Router port bundles
	wire          inj_valid  [`NUM_PORTS];
	wire          inj_accept [`NUM_PORTS];
	wire packet_t inj_pkt    [`NUM_PORTS];
	wire          ej_valid   [`NUM_PORTS];
	wire          ej_accept  [`NUM_PORTS];
	wire packet_t ej_pkt     [`NUM_PORTS];

	tile_router_network u_network (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_inj_valid  (inj_valid),
		.o_inj_accept (inj_accept),
		.i_inj_pkt    (inj_pkt),
		.o_ej_valid   (ej_valid),
		.i_ej_accept  (ej_accept),
		.o_ej_pkt     (ej_pkt)
	);

	////////////////////
	// Port role mapping
	////////////////////

	// Controller
	assign inj_valid[`PORT_CTRL]          = i_layer_eng_ctrl_output_valid;
	assign inj_pkt[`PORT_CTRL]            = i_layer_eng_ctrl_output_data;
	assign o_layer_eng_ctrl_output_accept = inj_accept[`PORT_CTRL];
	assign o_layer_eng_ctrl_input_valid   = ej_valid[`PORT_CTRL];
	assign o_layer_eng_ctrl_input_data    = ej_pkt[`PORT_CTRL];
	assign ej_accept[`PORT_CTRL]          = i_layer_eng_ctrl_input_accept;

	// IO element k sits on router port PORT_IO_FIRST + k
	for (genvar k = 0; k < `NUM_IO_PORTS; k++) begin : g_io
		localparam int port_idx = `PORT_IO_FIRST + k;

		assign inj_valid[port_idx]             = i_layer_eng_io_output_valid[k];
		assign inj_pkt[port_idx]               = i_layer_eng_io_output_data[k];
		assign o_layer_eng_io_output_accept[k] = inj_accept[port_idx];
		assign o_layer_eng_io_input_valid[k]   = ej_valid[port_idx];
		assign o_layer_eng_io_input_data[k]    = ej_pkt[port_idx];
		assign ej_accept[port_idx]             = i_layer_eng_io_input_accept[k];
	end

	// Message interface
	msg_intf u_msg_intf (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_recv_msg_request (i_recv_msg_request),
		.i_recv_msg_dest    (i_recv_msg_dest),
		.o_recv_msg_ack     (o_recv_msg_ack),
		.i_recv_msg_valid   (i_recv_msg_valid),
		.i_recv_msg_last    (i_recv_msg_last),
		.i_recv_msg_payload (i_recv_msg_payload),
		.o_recv_msg_accept  (o_recv_msg_accept),
		.o_send_msg_valid   (o_send_msg_valid),
		.i_send_msg_dst_rdy (i_send_msg_dst_rdy),
		.o_send_msg_payload (o_send_msg_payload),
		.o_send_msg_src     (o_send_msg_src),
		.o_send_msg_kind    (o_send_msg_kind),
		.o_pkt_out_valid    (inj_valid[`PORT_MSG]),
		.i_pkt_out_accept   (inj_accept[`PORT_MSG]),
		.o_pkt_out          (inj_pkt[`PORT_MSG]),
		.i_pkt_in_valid     (ej_valid[`PORT_MSG]),
		.o_pkt_in_accept    (ej_accept[`PORT_MSG]),
		.i_pkt_in           (ej_pkt[`PORT_MSG])
	);

endmodule

//--- dv/tb_layer_engine_docker.sv
`timescale 1ns/100ps
`include "noc_params.svh"

module tb_layer_engine_docker
	import noc_pkg::*;
;
	localparam int TOTAL_CYCLES = 6000;

	logic i_clk = 1'b0;
	logic i_rst_n = 1'b0;
	logic inj_valid [`NUM_PORTS];
	packet_t inj_pkt [`NUM_PORTS];
	logic ej_accept [`NUM_PORTS];
	wire inj_acc [`NUM_PORTS];
	wire ej_v [`NUM_PORTS];
	wire packet_t ej_pkt [`NUM_PORTS];
	logic recv_req = 1'b0;
	port_id_t recv_dest = '0;
	logic recv_last = 1'b0;
	wire recv_ack;
	logic [`MSG_BEAT_W-1:0] send_payload;
	port_id_t send_src;
	pkt_kind_e send_kind;
	logic ctrl_in_v;
	logic [`PACKET_W-1:0] ctrl_in_d;
	logic [`NUM_IO_PORTS-1:0] io_v;
	logic [`NUM_IO_PORTS-1:0] io_acc;
	logic [`NUM_IO_PORTS-1:0] io_in_v;
	logic [`NUM_IO_PORTS-1:0] io_in_acc;
	logic [`NUM_IO_PORTS-1:0][`PACKET_W-1:0] io_d;
	logic [`NUM_IO_PORTS-1:0][`PACKET_W-1:0] io_in_d;
	packet_t exp_q [`NUM_PORTS][$];
	int cyc = 0;
	int outstanding = 0;
	int msg_seen = 0;
	int errors = 0;
	int seq = 0;
	int n_pass = 0;
	int n_fail = 0;

	always #4 i_clk = ~i_clk;

	for (genvar k = 0; k < `NUM_IO_PORTS; k++) begin : g_io
		assign io_v[k]                         = inj_valid[`PORT_IO_FIRST + k];
		assign io_d[k]                         = inj_pkt[`PORT_IO_FIRST + k];
		assign inj_acc[`PORT_IO_FIRST + k]     = io_acc[k];
		assign ej_v[`PORT_IO_FIRST + k]        = io_in_v[k];
		assign ej_pkt[`PORT_IO_FIRST + k]      = io_in_d[k];
		assign io_in_acc[k]                    = ej_accept[`PORT_IO_FIRST + k];
	end
	assign ej_v[`PORT_CTRL]   = ctrl_in_v;
	assign ej_pkt[`PORT_CTRL] = ctrl_in_d;
	// Send side has no dest field so it is rebuilt as port 1
	assign ej_pkt[`PORT_MSG]  = {4'd1, {1'b0, send_src}, send_kind, send_payload};

	layer_engine_docker uut (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_recv_msg_request(recv_req), .i_recv_msg_dest(recv_dest),
		.o_recv_msg_ack(recv_ack), .i_recv_msg_valid(inj_valid[`PORT_MSG]),
		.i_recv_msg_last(recv_last), .i_recv_msg_payload(inj_pkt[`PORT_MSG].payload),
		.o_recv_msg_accept(inj_acc[`PORT_MSG]),
		.o_send_msg_valid(ej_v[`PORT_MSG]), .i_send_msg_dst_rdy(ej_accept[`PORT_MSG]),
		.o_send_msg_payload(send_payload), .o_send_msg_src(send_src),
		.o_send_msg_kind(send_kind),
		.i_layer_eng_ctrl_output_valid(inj_valid[`PORT_CTRL]),
		.o_layer_eng_ctrl_output_accept(inj_acc[`PORT_CTRL]),
		.i_layer_eng_ctrl_output_data(inj_pkt[`PORT_CTRL]),
		.o_layer_eng_ctrl_input_valid(ctrl_in_v),
		.i_layer_eng_ctrl_input_accept(ej_accept[`PORT_CTRL]),
		.o_layer_eng_ctrl_input_data(ctrl_in_d),
		.i_layer_eng_io_output_valid(io_v), .o_layer_eng_io_output_accept(io_acc),
		.i_layer_eng_io_output_data(io_d), .o_layer_eng_io_input_valid(io_in_v),
		.i_layer_eng_io_input_accept(io_in_acc), .o_layer_eng_io_input_data(io_in_d)
	);

	task automatic check_packet(string name, packet_t exp, packet_t act);
		if (act !== exp) begin
			$display("** Error %s: expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_kind(string name, pkt_kind_e exp, pkt_kind_e act);
		if (act !== exp) begin
			$display("** Error %s: expected %s actual %s", name, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act !== exp) begin
			$display("** Error %s: expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	function automatic packet_t make_pkt(int s, int d);
		packet_t p;
		p.dest    = 4'(d);
		p.src     = 4'(s);
		p.kind    = pkt_kind_e'($urandom_range(2, 0));
		p.payload = {24'($urandom), 32'(seq)};
		seq++;
		return p;
	endfunction

	////////////////////
	// Reference model
	////////////////////

	always @(posedge i_clk) begin
		int hit;
		cyc <= cyc + 1;
		if (i_rst_n) begin
			for (int p = 0; p < `NUM_PORTS; p++) begin
				if (inj_valid[p] && inj_acc[p]) begin
					exp_q[inj_pkt[p].dest[`PORT_ID_W-1:0]].push_back(inj_pkt[p]);
					outstanding++;
				end
				if (ej_v[p] && ej_accept[p]) begin
					hit = -1;
					for (int i = 0; i < exp_q[p].size(); i++) begin
						if (exp_q[p][i].payload == ej_pkt[p].payload) begin
							hit = i;
						end
					end
					if (hit < 0) begin
						$display("Unexpected packet %h ejected at port %0d", ej_pkt[p], p);
						errors++;
					end else begin
						check_packet($sformatf("eject port %0d", p), exp_q[p][hit], ej_pkt[p]);
						if (p == `PORT_MSG) begin
							check_kind("send kind", exp_q[p][hit].kind, send_kind);
						end
						if (ej_pkt[p].kind == PKT_MSG && ej_pkt[p].src == 4'd1) begin
							msg_seen++;
						end
						exp_q[p].delete(hit);
						outstanding--;
					end
				end
			end
		end
	end

	// Model counts change on the rising edge and are read on the falling one
	task automatic wait_drain();
		int n = 0;
		@(negedge i_clk);
		while (outstanding != 0 && n < 2000) begin
			@(negedge i_clk);
			n++;
		end
		if (outstanding != 0) begin
			$display("%0d packets were never delivered", outstanding);
			errors++;
		end
	endtask

	// fixed_dest below zero picks a random destination for every packet
	task automatic run_traffic(int n_per_port, bit back_pressure, int fixed_dest);
		int sent [`NUM_PORTS];
		bit done;
		foreach (sent[p]) sent[p] = 0;
		do begin
			@(posedge i_clk);
			done = 1'b1;
			for (int p = 0; p < `NUM_PORTS; p++) begin
				if (p != `PORT_MSG) begin
					if (inj_valid[p] && inj_acc[p]) sent[p]++;
					if (!inj_valid[p] || inj_acc[p]) begin
						inj_valid[p] <= (sent[p] < n_per_port);
						inj_pkt[p]   <= make_pkt(p, fixed_dest < 0 ?
							$urandom_range(7, 0) : fixed_dest);
					end
					if (sent[p] < n_per_port) done = 1'b0;
				end
				ej_accept[p] <= back_pressure ? ($urandom_range(3, 0) != 0) : 1'b1;
			end
		end while (!done);
		foreach (ej_accept[p]) ej_accept[p] <= 1'b1;
		wait_drain();
	endtask

	task automatic msg_session(int dest, int beats);
		int base = msg_seen;
		packet_t beat;
		@(posedge i_clk);
		recv_req  <= 1'b1;
		recv_dest <= port_id_t'(dest);
		@(posedge i_clk);
		recv_req <= 1'b0;
		check_count("ack early", 0, recv_ack);
		@(posedge i_clk);
		check_count("ack", 1, recv_ack);
		for (int b = 0; b < beats; b++) begin
			beat      = make_pkt(1, dest);
			beat.kind = PKT_MSG;
			inj_valid[`PORT_MSG] <= 1'b1;
			inj_pkt[`PORT_MSG]   <= beat;
			recv_last            <= (b == beats - 1);
			do begin
				@(posedge i_clk);
				check_count("ack length", 0, recv_ack);
			end while (!inj_acc[`PORT_MSG]);
		end
		inj_valid[`PORT_MSG] <= 1'b0;
		recv_last            <= 1'b0;
		wait_drain();
		check_count("message beats", beats, msg_seen - base);
	endtask

	task automatic end_test(string name, int err_before);
		if (errors == err_before) n_pass++;
		else n_fail++;
		$display("%s: %s", name, errors == err_before ? "ok" : "failed");
	endtask

	initial begin
		int e;
		packet_t pkt;
		int t0;
		int n;
		void'($urandom(40));
		foreach (inj_valid[p]) begin
			inj_valid[p] = 1'b0;
			inj_pkt[p]   = '0;
			ej_accept[p] = 1'b1;
		end
		repeat (16) @(posedge i_clk);
		i_rst_n <= 1'b1;

		e = errors;
		foreach (ej_v[p]) check_count("reset valid", 0, ej_v[p]);
		check_count("reset ack", 0, recv_ack);
		end_test("reset", e);

		// Idle ring latency from every IO port to every port
		e = errors;
		for (int s = `PORT_IO_FIRST; s < `NUM_PORTS; s++) begin
			for (int d = 0; d < `NUM_PORTS; d++) begin
				pkt = make_pkt(s, d);
				inj_valid[s] <= 1'b1;
				inj_pkt[s]   <= pkt;
				do @(posedge i_clk); while (!inj_acc[s]);
				t0 = cyc;
				inj_valid[s] <= 1'b0;
				n = 0;
				do begin
					@(posedge i_clk);
					n++;
				end while (!ej_v[d] && n < 50);
				if (!ej_v[d]) begin
					$display("Packet from port %0d to port %0d never arrived", s, d);
					errors++;
				end
				check_count("latency", ((d - s - 1 + 8) % 8) + 1, cyc - t0);
				check_packet("idle packet", pkt, ej_pkt[d]);
			end
		end
		wait_drain();
		end_test("idle latency", e);

		e = errors;
		run_traffic(40, 1'b0, -1);
		end_test("random traffic", e);
		e = errors;
		run_traffic(40, 1'b1, -1);
		end_test("back-pressure traffic", e);
		e = errors;
		for (int i = 0; i < 8; i++) msg_session(i, $urandom_range(6, 1));
		end_test("message sessions", e);
		e = errors;
		run_traffic(10, 1'b1, `PORT_MSG);
		end_test("send side", e);

		$display("passed %0d failed %0d", n_pass, n_fail);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TOTAL_CYCLES * 20 * 8);
		$display("Watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- layer_engine_docker.f
+incdir+rtl
rtl/noc_pkg.sv
rtl/ring_router_node.sv
rtl/tile_router_network.sv
rtl/msg_intf.sv
rtl/layer_engine_docker.sv
dv/tb_layer_engine_docker.sv

//--- Bender.yml
package:
  name: layer_engine_docker

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/noc_pkg.sv
      - rtl/ring_router_node.sv
      - rtl/tile_router_network.sv
      - rtl/msg_intf.sv
      - rtl/layer_engine_docker.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/tb_layer_engine_docker.sv
